//--- sim.f
+incdir+include
src/uart_cfg_pkg.sv
src/rx_frame_check.sv
src/cfg_slave_fsm.sv
src/uart_cfg_ctrl.sv
tests/tb_uart_cfg_ctrl.sv

//--- Makefile
# Verilator build and run of the UART configuration controller testbench

VERILATOR  ?= verilator
TOP        := tb_uart_cfg_ctrl
RTL_TOP    := uart_cfg_ctrl
FILELIST   := sim.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall
RTL_SRCS   := src/uart_cfg_pkg.sv src/rx_frame_check.sv src/cfg_slave_fsm.sv \
              src/uart_cfg_ctrl.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

//--- include/tb_cfg_vectors.svh
/* Stimulus table: one row per step with the frame settings and the
   acknowledgment, configuration error and done flags expected after it */
`ifndef TB_CFG_VECTORS_SVH
`define TB_CFG_VECTORS_SVH

localparam int NUM_STEPS = 27;

// Columns: kind, byte, parity flip, width, parity, stop, ack, cfg error, done
localparam step_t STEPS [NUM_STEPS] = '{
    // Plain data under the standard frame, a marked byte is just data here
    '{K_SEND,    8'h3C, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    '{K_SEND,    8'hA5, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    '{K_SEND,    8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    '{K_SEND,    8'h7E, 1'b1, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    // Disabled request, then a session: 7 bits, odd parity, stop code 1
    '{K_REQ_OFF, 8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    '{K_REQ,     8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'h55, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0},
    '{K_SEND,    8'hA2, 1'b0, 2'd2, 2'd0, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hA5, 1'b0, 2'd2, 2'd1, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hA9, 1'b0, 2'd2, 2'd1, 2'd1, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hAC, 1'b0, 2'd2, 2'd1, 2'd1, 1'b1, 1'b0, 1'b1},
    // Data under the new frame, bit 7 lies outside it
    '{K_SEND,    8'h4B, 1'b0, 2'd2, 2'd1, 2'd1, 1'b0, 1'b0, 1'b1},
    '{K_SEND,    8'hC3, 1'b1, 2'd2, 2'd1, 2'd1, 1'b0, 1'b0, 1'b1},
    '{K_SEND,    8'h81, 1'b0, 2'd2, 2'd1, 2'd1, 1'b0, 1'b0, 1'b1},
    '{K_STD,     8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    // Second session: no parity and 5 data bits
    '{K_REQ,     8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hA7, 1'b0, 2'd3, 2'd3, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hA0, 1'b0, 2'd0, 2'd3, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hAC, 1'b0, 2'd0, 2'd3, 2'd0, 1'b1, 1'b0, 1'b1},
    '{K_SEND,    8'h1F, 1'b1, 2'd0, 2'd3, 2'd0, 1'b0, 1'b0, 1'b1},
    '{K_SEND,    8'hE4, 1'b0, 2'd0, 2'd3, 2'd0, 1'b0, 1'b0, 1'b1},
    // Silent session times out and reloads the standard frame
    '{K_REQ,     8'h00, 1'b0, 2'd0, 2'd3, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_WAIT,    8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b1, 1'b1},
    '{K_SEND,    8'h99, 1'b1, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1},
    // Marked packet with a bad parity bit aborts the session
    '{K_REQ,     8'h00, 1'b0, 2'd3, 2'd0, 2'd0, 1'b1, 1'b0, 1'b0},
    '{K_SEND,    8'hA1, 1'b1, 2'd3, 2'd0, 2'd0, 1'b0, 1'b1, 1'b1},
    '{K_SEND,    8'h5A, 1'b0, 2'd3, 2'd0, 2'd0, 1'b0, 1'b0, 1'b1}
};

`endif

//--- tests/tb_uart_cfg_ctrl.sv
/* Testbench for the UART configuration controller: clock, reset, table-driven
   steps, random back-pressure, output monitor, compare tasks and watchdog */
module tb_uart_cfg_ctrl;
    import uart_cfg_pkg::*;

    // Step kinds used in the stimulus table
    localparam logic [2:0] K_SEND    = 3'd0;
    localparam logic [2:0] K_REQ     = 3'd1;
    localparam logic [2:0] K_REQ_OFF = 3'd2;
    localparam logic [2:0] K_STD     = 3'd3;
    localparam logic [2:0] K_WAIT    = 3'd4;

    typedef struct packed {
        logic [2:0]   kind;
        uart_byte_t   data;
        logic         flip;
        data_width_t  exp_dw;
        parity_mode_t exp_pm;
        stop_bits_t   exp_sb;
        logic         exp_ack;
        logic         exp_cerr;
        logic         exp_done;
    } step_t;

    `include "tb_cfg_vectors.svh"

    // Each step gets a generous budget, the silence step needs a full timeout
    localparam int CYCLE_LIMIT   = NUM_STEPS * 64 + 3 * TIMEOUT_CYCLES;
    localparam int SETTLE_CYCLES = 4;

    logic         clk_i;
    logic         rst_n_i;
    logic         rx_valid_i;
    logic         rx_ready_o;
    uart_byte_t   rx_data_i;
    logic         rx_parity_i;
    logic         cfg_req_i;
    logic         cfg_enable_i;
    logic         std_config_i;
    logic         data_valid_o;
    logic         data_ready_i = 1'b0;
    uart_byte_t   data_o;
    logic         tx_valid_o;
    logic         tx_ready_i = 1'b0;
    uart_byte_t   tx_data_o;
    data_width_t  data_width_o;
    parity_mode_t parity_mode_o;
    stop_bits_t   stop_bits_o;
    logic         config_done_o;
    logic         config_error_o;
    logic         parity_error_o;

    logic [31:0]  lcg_state = 32'd12109;
    int           cycle_cnt = 0;
    int           ack_cnt   = 0;
    int           perr_cnt  = 0;
    int           cerr_cnt  = 0;
    string        step_name = "reset";
    // Bytes expected on the data output, oldest first
    uart_byte_t   exp_q [$];

    uart_cfg_ctrl i_uart_cfg_ctrl (.*);

    always #20 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Line parity for a character: XOR of the frame's data bits, inverted for odd
    function automatic logic line_parity(uart_byte_t data, data_width_t dw, parity_mode_t pm);
        logic x;
        x = 1'b0;
        for (int b = 0; b < 5 + int'(dw); b++) begin
            x ^= data[b];
        end
        return (pm == PARITY_ODD) ? ~x : x;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_settings(input string name, input data_width_t exp_dw,
                                  input parity_mode_t exp_pm, input stop_bits_t exp_sb,
                                  input data_width_t act_dw, input parity_mode_t act_pm,
                                  input stop_bits_t act_sb);
        if (act_dw !== exp_dw || act_pm !== exp_pm || act_sb !== exp_sb) begin
            $display("error: %s settings expected %h/%h/%h actual %h/%h/%h",
                     name, exp_dw, exp_pm, exp_sb, act_dw, act_pm, act_sb);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // A pulse may show up at most once per step
    task automatic check_pulses(input string name, input logic exp, input int delta);
        if (delta > 1) begin
            $display("%s produced %0d pulses where at most one was allowed", name, delta);
            abort_run();
        end
        check_flag(name, exp, delta == 1);
    endtask

    // Holds the character on the rx port until the stage takes it
    task automatic send_byte(input uart_byte_t data, input logic parity);
        rx_valid_i  = 1'b1;
        rx_data_i   = data;
        rx_parity_i = parity;
        do @(posedge clk_i); while (!rx_ready_o);
        @(negedge clk_i);
        rx_valid_i = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Back-pressure, monitor and watchdog
    // ----------------------------------------------------------------------

    always @(negedge clk_i) begin : backpressure
        logic [31:0] rnd;
        rnd          = lcg_next();
        data_ready_i = rnd[16];
        tx_ready_i   = rnd[21];
    end : backpressure

    // Transfers are sampled at the rising edge, half a cycle after the inputs moved
    always @(posedge clk_i) begin : monitor
        uart_byte_t exp_byte;
        if (rst_n_i) begin
            if (data_valid_o && data_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected byte %h on the data output in %s", data_o, step_name);
                    abort_run();
                end
                exp_byte = exp_q.pop_front();
                check_byte({step_name, " data"}, exp_byte, data_o);
            end
            if (tx_valid_o && tx_ready_i) begin
                check_byte({step_name, " ack byte"}, ACKN_PKT, tx_data_o);
                ack_cnt++;
            end
            if (parity_error_o) begin
                perr_cnt++;
            end
            if (config_error_o) begin
                cerr_cnt++;
            end
        end
    end : monitor

    always @(posedge clk_i) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end : watchdog

    // ----------------------------------------------------------------------
    // Table loop
    // ----------------------------------------------------------------------

    initial begin : run_table
        step_t        st;
        int           ack0;
        int           perr0;
        int           cerr0;
        logic         exp_perr;
        logic         in_main;
        data_width_t  cur_dw;
        parity_mode_t cur_pm;

        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        rx_valid_i   = 1'b0;
        rx_data_i    = '0;
        rx_parity_i  = 1'b0;
        cfg_req_i    = 1'b0;
        cfg_enable_i = 1'b1;
        std_config_i = 1'b0;
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        check_settings("reset", STD_DATA_WIDTH, STD_PARITY_MODE, STD_STOP_BITS,
                       data_width_o, parity_mode_o, stop_bits_o);
        check_flag("reset done", 1'b1, config_done_o);
        check_flag("reset data valid", 1'b0, data_valid_o);
        check_flag("reset tx valid", 1'b0, tx_valid_o);

        // Reference settings, the ones in force when the next byte is sent
        cur_dw  = STD_DATA_WIDTH;
        cur_pm  = STD_PARITY_MODE;
        in_main = 1'b1;

        for (int i = 0; i < NUM_STEPS; i++) begin
            st        = STEPS[i];
            step_name = $sformatf("step %0d", i);
            ack0      = ack_cnt;
            perr0     = perr_cnt;
            cerr0     = cerr_cnt;
            exp_perr  = 1'b0;

            case (st.kind)
                K_SEND: begin
                    // A wrong bit only counts while a parity mode is active
                    exp_perr = st.flip && (cur_pm == PARITY_EVEN || cur_pm == PARITY_ODD);
                    if (in_main) begin
                        exp_q.push_back(st.data);
                    end
                    send_byte(st.data, line_parity(st.data, cur_dw, cur_pm) ^ st.flip);
                end
                K_REQ, K_REQ_OFF: begin
                    cfg_enable_i = st.kind == K_REQ;
                    cfg_req_i    = 1'b1;
                    @(negedge clk_i);
                    cfg_req_i    = 1'b0;
                    cfg_enable_i = 1'b1;
                end
                K_STD: begin
                    std_config_i = 1'b1;
                    @(negedge clk_i);
                    std_config_i = 1'b0;
                end
                default: begin
                    // Silence, the session has to run into its timeout
                end
            endcase

            // Wait for every response the step promises, then let the FSM settle
            while ((st.exp_ack && ack_cnt == ack0) || (st.exp_cerr && cerr_cnt == cerr0) ||
                   exp_q.size() != 0) begin
                @(negedge clk_i);
            end
            repeat (SETTLE_CYCLES) @(negedge clk_i);

            check_pulses({step_name, " ack count"}, st.exp_ack, ack_cnt - ack0);
            check_pulses({step_name, " parity error"}, exp_perr, perr_cnt - perr0);
            check_pulses({step_name, " config error"}, st.exp_cerr, cerr_cnt - cerr0);
            check_settings(step_name, st.exp_dw, st.exp_pm, st.exp_sb,
                           data_width_o, parity_mode_o, stop_bits_o);
            check_flag({step_name, " done"}, st.exp_done, config_done_o);

            cur_dw  = st.exp_dw;
            cur_pm  = st.exp_pm;
            in_main = st.exp_done;
        end

        $display("Simulation finished: PASS");
        $finish;
    end : run_table

endmodule : tb_uart_cfg_ctrl

//--- src/uart_cfg_ctrl.sv
/* Top level of the UART configuration controller */
module uart_cfg_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       rx_valid_i,
    output logic                       rx_ready_o,
    input  uart_cfg_pkg::uart_byte_t   rx_data_i,
    input  logic                       rx_parity_i,
    input  logic                       cfg_req_i,
    input  logic                       cfg_enable_i,
    input  logic                       std_config_i,
    output logic                       data_valid_o,
    input  logic                       data_ready_i,
    output uart_cfg_pkg::uart_byte_t   data_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    output uart_cfg_pkg::uart_byte_t   tx_data_o,
    output uart_cfg_pkg::data_width_t  data_width_o,
    output uart_cfg_pkg::parity_mode_t parity_mode_o,
    output uart_cfg_pkg::stop_bits_t   stop_bits_o,
    output logic                       config_done_o,
    output logic                       config_error_o,
    output logic                       parity_error_o
);
    import uart_cfg_pkg::*;

    // Frame-check stage output
    logic       chk_valid;
    logic       chk_ready;
    uart_byte_t chk_data;
    logic       chk_parity_err;

    // The stage checks against the settings the FSM currently drives
    rx_frame_check i_rx_frame_check (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .rx_valid_i       (rx_valid_i),
        .rx_ready_o       (rx_ready_o),
        .rx_data_i        (rx_data_i),
        .rx_parity_i      (rx_parity_i),
        .data_width_i     (data_width_o),
        .parity_mode_i    (parity_mode_o),
        .chk_valid_o      (chk_valid),
        .chk_ready_i      (chk_ready),
        .chk_data_o       (chk_data),
        .chk_parity_err_o (chk_parity_err),
        .parity_error_o   (parity_error_o)
    );

    cfg_slave_fsm i_cfg_slave_fsm (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .chk_valid_i      (chk_valid),
        .chk_ready_o      (chk_ready),
        .chk_data_i       (chk_data),
        .chk_parity_err_i (chk_parity_err),
        .cfg_req_i        (cfg_req_i),
        .cfg_enable_i     (cfg_enable_i),
        .std_config_i     (std_config_i),
        .data_valid_o     (data_valid_o),
        .data_ready_i     (data_ready_i),
        .data_o           (data_o),
        .tx_valid_o       (tx_valid_o),
        .tx_ready_i       (tx_ready_i),
        .tx_data_o        (tx_data_o),
        .data_width_o     (data_width_o),
        .parity_mode_o    (parity_mode_o),
        .stop_bits_o      (stop_bits_o),
        .config_done_o    (config_done_o),
        .config_error_o   (config_error_o)
    );

endmodule : uart_cfg_ctrl

//--- src/cfg_slave_fsm.sv
/* Slave configuration FSM: forwards data while idle, runs the
   configuration session with timeout and holds the active frame settings */
module cfg_slave_fsm (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // Checked characters from the frame-check stage
    input  logic                       chk_valid_i,
    output logic                       chk_ready_o,
    input  uart_cfg_pkg::uart_byte_t   chk_data_i,
    input  logic                       chk_parity_err_i,
    // Session control
    input  logic                       cfg_req_i,
    input  logic                       cfg_enable_i,
    input  logic                       std_config_i,
    // Downstream data
    output logic                       data_valid_o,
    input  logic                       data_ready_i,
    output uart_cfg_pkg::uart_byte_t   data_o,
    // Acknowledgment towards the transmitter
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    output uart_cfg_pkg::uart_byte_t   tx_data_o,
    // Active frame settings and status
    output uart_cfg_pkg::data_width_t  data_width_o,
    output uart_cfg_pkg::parity_mode_t parity_mode_o,
    output uart_cfg_pkg::stop_bits_t   stop_bits_o,
    output logic                       config_done_o,
    output logic                       config_error_o
);
    import uart_cfg_pkg::*;

    cfg_state_e   state_q;
    cfg_state_e   state_d;
    timeout_cnt_t timeout_cnt_q;
    logic         end_seen_q;
    logic         config_error_q;

    data_width_t  data_width_q;
    parity_mode_t parity_mode_q;
    stop_bits_t   stop_bits_q;

    // Decoded fields of the character at the stage output
    logic         pkt_marked;
    cfg_id_t      pkt_id;
    cfg_option_t  pkt_option;

    logic         pkt_apply;
    logic         cfg_fail;
    logic         timeout_hit;

    assign pkt_marked = chk_data_i[7:4] == CFG_MARKER;
    assign pkt_id     = cfg_id_t'(chk_data_i[3:2]);
    assign pkt_option = cfg_option_t'(chk_data_i[1:0]);

    // The counter starts at zero on entry, so this is the last SETUP cycle
    assign timeout_hit = timeout_cnt_q == timeout_cnt_t'(TIMEOUT_CYCLES - 1);

    // ----------------------------------------------------------------------
    // Next state and handshakes
    // ----------------------------------------------------------------------

    always_comb begin : next_state_logic
        state_d      = state_q;
        chk_ready_o  = 1'b0;
        data_valid_o = 1'b0;
        tx_valid_o   = 1'b0;
        pkt_apply    = 1'b0;
        cfg_fail     = 1'b0;

        case (state_q)
            MAIN: begin
                // Data passes straight through while no session runs
                chk_ready_o  = data_ready_i;
                data_valid_o = chk_valid_i;
                // A remote request wins over a local standard reload
                if (cfg_req_i && cfg_enable_i) begin
                    state_d = SEND_ACKN;
                end else if (std_config_i) begin
                    state_d = STD_CONFIG;
                end
            end

            SEND_ACKN: begin
                tx_valid_o = 1'b1;
                if (tx_ready_i) begin
                    state_d = end_seen_q ? MAIN : SETUP;
                end
            end

            SETUP: begin
                // Every byte is consumed here, data traffic is not forwarded
                chk_ready_o = 1'b1;
                if (chk_valid_i && chk_parity_err_i) begin
                    cfg_fail = 1'b1;
                    state_d  = STD_CONFIG;
                end else if (chk_valid_i && pkt_marked) begin
                    pkt_apply = 1'b1;
                    state_d   = SEND_ACKN;
                end else if (timeout_hit) begin
                    cfg_fail = 1'b1;
                    state_d  = STD_CONFIG;
                end
            end

            STD_CONFIG: begin
                state_d = MAIN;
            end
        endcase
    end : next_state_logic

    // ----------------------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : control_regs
        if (!rst_n_i) begin
            state_q        <= MAIN;
            timeout_cnt_q  <= '0;
            end_seen_q     <= 1'b0;
            config_error_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            config_error_q <= cfg_fail;

            // Counts only inside SETUP; a stalled acknowledgment does not age it
            if (state_q == SETUP) begin
                timeout_cnt_q <= timeout_cnt_q + 1'b1;
            end else begin
                timeout_cnt_q <= '0;
            end

            // Remembers whether the packet being acknowledged ends the session
            if (state_q == MAIN) begin
                end_seen_q <= 1'b0;
            end else if (pkt_apply) begin
                end_seen_q <= pkt_id == CFG_ID_END;
            end
        end
    end : control_regs

    // ----------------------------------------------------------------------
    // Frame settings
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : setting_regs
        if (!rst_n_i || state_q == STD_CONFIG) begin
            data_width_q  <= STD_DATA_WIDTH;
            parity_mode_q <= STD_PARITY_MODE;
            stop_bits_q   <= STD_STOP_BITS;
        end else if (pkt_apply) begin
            // The end packet carries no option
            case (pkt_id)
                CFG_ID_DATA_WIDTH:  data_width_q  <= data_width_t'(pkt_option);
                CFG_ID_PARITY_MODE: parity_mode_q <= parity_mode_t'(pkt_option);
                CFG_ID_STOP_BITS:   stop_bits_q   <= stop_bits_t'(pkt_option);
                default:            ;
            endcase
        end
    end : setting_regs

    assign data_o         = chk_data_i;
    assign tx_data_o      = ACKN_PKT;
    assign data_width_o   = data_width_q;
    assign parity_mode_o  = parity_mode_q;
    assign stop_bits_o    = stop_bits_q;
    assign config_done_o  = state_q == MAIN;
    assign config_error_o = config_error_q;

endmodule : cfg_slave_fsm

//--- src/rx_frame_check.sv
/* Receive register stage: one-entry buffer that tags every accepted
   character with its parity verdict and pulses on a bad character */
module rx_frame_check (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // Receiver side
    input  logic                       rx_valid_i,
    output logic                       rx_ready_o,
    input  uart_cfg_pkg::uart_byte_t   rx_data_i,
    input  logic                       rx_parity_i,
    // Frame settings currently in force
    input  uart_cfg_pkg::data_width_t  data_width_i,
    input  uart_cfg_pkg::parity_mode_t parity_mode_i,
    // Checked character towards the controller FSM
    output logic                       chk_valid_o,
    input  logic                       chk_ready_i,
    output uart_cfg_pkg::uart_byte_t   chk_data_o,
    output logic                       chk_parity_err_o,
    output logic                       parity_error_o
);
    import uart_cfg_pkg::*;

    logic       buf_valid_q;
    uart_byte_t buf_data_q;
    logic       buf_err_q;
    logic       parity_error_q;

    logic       rx_accept;
    logic       data_xor;
    logic       parity_bad;

    // ----------------------------------------------------------------------
    // Parity check
    // ----------------------------------------------------------------------

    always_comb begin : parity_check
        // Only the bits that belong to the frame take part in the XOR
        case (data_width_i)
            DW_5BIT: data_xor = ^rx_data_i[4:0];
            DW_6BIT: data_xor = ^rx_data_i[5:0];
            DW_7BIT: data_xor = ^rx_data_i[6:0];
            default: data_xor = ^rx_data_i;
        endcase

        // Odd parity expects the inverse of the data XOR on the line
        case (parity_mode_i)
            PARITY_EVEN: parity_bad = rx_parity_i != data_xor;
            PARITY_ODD:  parity_bad = rx_parity_i != ~data_xor;
            default:     parity_bad = 1'b0;
        endcase
    end : parity_check

    // ----------------------------------------------------------------------
    // One-entry buffer
    // ----------------------------------------------------------------------

    // Ready while empty or while the held character leaves this cycle
    assign rx_ready_o = !buf_valid_q || chk_ready_i;
    assign rx_accept  = rx_valid_i && rx_ready_o;

    always_ff @(posedge clk_i) begin : buffer_ctrl
        if (!rst_n_i) begin
            buf_valid_q    <= 1'b0;
            parity_error_q <= 1'b0;
        end else begin
            if (rx_accept) begin
                buf_valid_q <= 1'b1;
            end else if (chk_ready_i) begin
                buf_valid_q <= 1'b0;
            end
            // One pulse per accepted bad character
            parity_error_q <= rx_accept && parity_bad;
        end
    end : buffer_ctrl

    // Payload and verdict, captured with the settings at acceptance
    always_ff @(posedge clk_i) begin : buffer_data
        if (rx_accept) begin
            buf_data_q <= rx_data_i;
            buf_err_q  <= parity_bad;
        end
    end : buffer_data

    assign chk_valid_o      = buf_valid_q;
    assign chk_data_o       = buf_data_q;
    assign chk_parity_err_o = buf_err_q;
    assign parity_error_o   = parity_error_q;

endmodule : rx_frame_check

//--- src/uart_cfg_pkg.sv
/* Frame-setting and packet field types, the configuration state
   encoding and the constants shared by the UART configuration controller */
package uart_cfg_pkg;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    // One character on the serial line
    typedef logic [7:0] uart_byte_t;

    // Frame settings, each a 2-bit code
    typedef logic [1:0] data_width_t;
    typedef logic [1:0] parity_mode_t;
    typedef logic [1:0] stop_bits_t;

    // Configuration packet fields
    typedef logic [1:0] cfg_id_t;
    typedef logic [1:0] cfg_option_t;

    // Session states of the slave controller
    typedef enum logic [1:0] {
        MAIN,
        SEND_ACKN,
        SETUP,
        STD_CONFIG
    } cfg_state_e;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------

    // Data width codes, 5 to 8 data bits
    localparam data_width_t DW_5BIT = 2'd0;
    localparam data_width_t DW_6BIT = 2'd1;
    localparam data_width_t DW_7BIT = 2'd2;
    localparam data_width_t DW_8BIT = 2'd3;

    // Parity codes 2 and 3 both disable the check
    localparam parity_mode_t PARITY_EVEN = 2'd0;
    localparam parity_mode_t PARITY_ODD  = 2'd1;

    // Packet ids carried in bits 3:2 of a configuration packet
    localparam cfg_id_t CFG_ID_DATA_WIDTH  = 2'd0;
    localparam cfg_id_t CFG_ID_PARITY_MODE = 2'd1;
    localparam cfg_id_t CFG_ID_STOP_BITS   = 2'd2;
    localparam cfg_id_t CFG_ID_END         = 2'd3;

    // Upper nibble that tags a byte as a configuration packet
    localparam logic [3:0] CFG_MARKER = 4'b1010;
    localparam uart_byte_t ACKN_PKT   = 8'hFF;

    // Standard frame: 8 data bits, even parity, stop code 0
    localparam data_width_t  STD_DATA_WIDTH  = DW_8BIT;
    localparam parity_mode_t STD_PARITY_MODE = PARITY_EVEN;
    localparam stop_bits_t   STD_STOP_BITS   = 2'd0;

    // ----------------------------------------------------------------------
    // Timing
    // ----------------------------------------------------------------------

    localparam int unsigned CLOCK_FREQ_HZ  = 100_000;
    // 10 ms expressed in system clock cycles
    localparam int unsigned TIMEOUT_CYCLES = CLOCK_FREQ_HZ / 100;
    localparam int unsigned TIMEOUT_CNT_W  = $clog2(TIMEOUT_CYCLES);

    typedef logic [TIMEOUT_CNT_W-1:0] timeout_cnt_t;

endpackage : uart_cfg_pkg
